/* Makefile */
# Verilator build and run of the 35x35 multiplier testbench
# "make sim" fails unless the run prints the pass line

TOP := mult35_tb

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f list.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

/* dv/mult35_tb.sv */
// ----------------------------------------------------------
// testbench for mult35_pipe, reference is the full 70-bit product
// delayed by PIPE_LATENCY, prod and out_valid checked every cycle
// ----------------------------------------------------------
module mult35_tb;

   localparam int CLK_PERIOD = 10;
   localparam int RST_CYCLES = 3;
   localparam int DRAIN      = mult_pkg::PIPE_LATENCY + 2;  // cycles to empty the pipe
   localparam int N_IDLE     = 10;   // idle cycles after the first reset
   localparam int N_CORNER   = 10;   // corner pairs
   localparam int N_RANDOM   = 200;  // back-to-back random pairs
   localparam int N_GAPS     = 200;  // random pairs with valid gaps
   localparam int N_AROUND   = 20;   // pairs before and after the mid-stream reset
   localparam int N_TESTS    = 5;

   // every cycle the run takes, the watchdog adds a margin on top
   localparam int TOTAL_CYCLES = RST_CYCLES + N_IDLE + N_CORNER + N_RANDOM + N_GAPS
                                 + 2 * N_AROUND + RST_CYCLES + (N_TESTS - 1) * DRAIN;

   // corner operands
   localparam mult_pkg::operand_t ONES     = '1;
   localparam mult_pkg::operand_t LO_CARRY = mult_pkg::operand_t'(1) << mult_pkg::LIMB_LO_W;
   localparam mult_pkg::operand_t LO_MAX   = LO_CARRY - 1;  // all ones in the low limb
   localparam mult_pkg::operand_t TOP_BIT  =
      mult_pkg::operand_t'(1) << ($bits(mult_pkg::operand_t) - 1);

   logic               CLK;
   logic               RST;
   mult_pkg::operand_t a;
   mult_pkg::operand_t b;
   logic               in_valid;
   mult_pkg::product_t prod;
   logic               out_valid;

   // reference pipe, exp_now is the pair at the inputs right now
   mult_pkg::product_t exp_now;
   mult_pkg::product_t exp_prod  [1:mult_pkg::PIPE_LATENCY];
   logic               exp_valid [1:mult_pkg::PIPE_LATENCY];

   int err_count;   // assertion failures so far
   int chk_count;   // passed product checks so far
   int err_mark;    // counts at the start of the running test
   int chk_mark;
   int n_pass;
   int n_fail;

   mult35_pipe dut_i (
      .CLK       (CLK),
      .RST       (RST),
      .a         (a),
      .b         (b),
      .in_valid  (in_valid),
      .prod      (prod),
      .out_valid (out_valid)
   );

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   // widen first so no product bit is lost
   assign exp_now = mult_pkg::product_t'(a) * mult_pkg::product_t'(b);

   // reset empties the reference like the pipe, so nothing stale survives
   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         for (int i = 1; i <= mult_pkg::PIPE_LATENCY; i++)
         begin
            exp_prod[i]  <= '0;
            exp_valid[i] <= 1'b0;
         end
      end
      else
      begin
         exp_prod[1]  <= exp_now;
         exp_valid[1] <= in_valid;
         for (int i = 2; i <= mult_pkg::PIPE_LATENCY; i++)
         begin
            exp_prod[i]  <= exp_prod[i-1];   // one entry older per edge
            exp_valid[i] <= exp_valid[i-1];
         end
      end
   end

   // sampled on the falling edge, all inputs and outputs settled there
   prod_check: assert property (@(negedge CLK) prod == exp_prod[mult_pkg::PIPE_LATENCY])
      chk_count++;
   else
   begin
      $display("FAILED at time %0t: prod expected %h, got %h", $time,
               exp_prod[mult_pkg::PIPE_LATENCY], prod);
      err_count++;
   end

   valid_check: assert property (@(negedge CLK) out_valid == exp_valid[mult_pkg::PIPE_LATENCY])
   else
   begin
      $display("FAILED at time %0t: out_valid expected %b, got %b", $time,
               exp_valid[mult_pkg::PIPE_LATENCY], out_valid);
      err_count++;
   end

   // outputs are forced clear while RST is held
   reset_check: assert property (@(negedge CLK) RST |-> (prod == '0 && !out_valid))
   else
   begin
      $display("FAILED at time %0t: prod and out_valid expected 0 and 0 in reset, got %h and %b",
               $time, prod, out_valid);
      err_count++;
   end

   // one pair per cycle, applied just after the rising edge
   task automatic send_pair(input mult_pkg::operand_t x, input mult_pkg::operand_t y,
                            input logic v);
      a        = x;
      b        = y;
      in_valid = v;
      @(posedge CLK);
      #1;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) send_pair('0, '0, 1'b0);
   endtask

   task automatic hold_reset(input int n);
      a        = '0;
      b        = '0;
      in_valid = 1'b0;
      RST      = 1'b1;   // asynchronous, takes effect at once
      repeat (n) @(posedge CLK);
      #1;
      RST = 1'b0;
   endtask

   // 35 random bits from two draws
   function automatic mult_pkg::operand_t rand_operand();
      return mult_pkg::operand_t'({$urandom(), $urandom()});
   endfunction

   task automatic start_test();
      err_mark = err_count;
      chk_mark = chk_count;
   endtask

   task automatic end_test(input string name);
      int errs;
      int chks;
      errs = err_count - err_mark;
      chks = chk_count - chk_mark;
      if (errs == 0 && chks > 0)
      begin
         n_pass++;
         $display("test %s: ok, %0d cycles checked", name, chks);
      end
      else
      begin
         n_fail++;
         if (chks == 0)
            $display("test %s: no product check ran, the assertions were never reached", name);
         else
            $display("test %s: %0d mismatches", name, errs);
      end
   endtask

   // watchdog, a run longer than all tests plus a margin is stuck
   initial
   begin
      #((TOTAL_CYCLES + 20) * CLK_PERIOD);
      $display("timeout: the run did not finish within %0d cycles", TOTAL_CYCLES + 20);
      $display("tests failed");
      $finish;
   end

   initial
   begin
      void'($urandom(32'hc071));
      CLK       = 1'b0;
      RST       = 1'b1;
      a         = '0;
      b         = '0;
      in_valid  = 1'b0;
      err_count = 0;
      chk_count = 0;
      n_pass    = 0;
      n_fail    = 0;

      start_test();
      hold_reset(RST_CYCLES);
      idle_cycles(N_IDLE);   // nothing valid yet, out_valid must stay low
      end_test("reset state");

      start_test();
      send_pair('0, '0, 1'b1);
      send_pair('0, ONES, 1'b1);
      send_pair(mult_pkg::operand_t'(1), mult_pkg::operand_t'(1), 1'b1);
      send_pair(mult_pkg::operand_t'(1), ONES, 1'b1);
      send_pair(LO_MAX, LO_MAX, 1'b1);      // limb boundary, below
      send_pair(LO_CARRY, LO_CARRY, 1'b1);  // limb boundary, above
      send_pair(LO_MAX, LO_CARRY, 1'b1);
      send_pair(ONES, ONES, 1'b1);          // largest product
      send_pair(TOP_BIT, ONES, 1'b1);
      send_pair(ONES, TOP_BIT, 1'b1);
      idle_cycles(DRAIN);
      end_test("corner operands");

      start_test();
      repeat (N_RANDOM) send_pair(rand_operand(), rand_operand(), 1'b1);
      idle_cycles(DRAIN);
      end_test("random stream");

      start_test();
      repeat (N_GAPS) send_pair(rand_operand(), rand_operand(), ($urandom() % 3) != 0);
      idle_cycles(DRAIN);
      end_test("valid gaps");

      start_test();
      repeat (N_AROUND) send_pair(rand_operand(), rand_operand(), 1'b1);
      hold_reset(RST_CYCLES);   // pipe full of valid pairs here
      repeat (N_AROUND) send_pair(rand_operand(), rand_operand(), 1'b1);
      idle_cycles(DRAIN);
      end_test("reset mid-stream");

      $display("tests run: %0d, passed: %0d, failed: %0d", N_TESTS, n_pass, n_fail);
      if (n_fail == 0 && err_count == 0)
      begin
         $display("all tests passed");
      end
      else
      begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

/* list.f */
rtl/mult_pkg.sv
rtl/dsp_pkg.sv
rtl/delay_line.sv
rtl/mult_slice.sv
rtl/mult35_pipe.sv
dv/mult35_tb.sv

/* rtl/delay_line.sv */
// ----------------------------------------------------------
// shift register of depth stages, all cleared by RST
// depth must be 1 or more
// ----------------------------------------------------------
module delay_line #(
   parameter int depth = 1,  // number of register stages
   parameter int width = 1   // bits per stage
) (
   input  logic             CLK,
   input  logic             RST,
   input  logic [width-1:0] d,
   output logic [width-1:0] q
);

   // stage[0] takes d, stage[depth-1] drives q
   logic [width-1:0] stage [depth];

   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         for (int i = 0; i < depth; i++)
         begin
            stage[i] <= '0;            // flush whatever was in flight
         end
      end
      else
      begin
         stage[0] <= d;
         for (int i = 1; i < depth; i++)
         begin
            stage[i] <= stage[i-1];    // move one stage per edge
         end
      end
   end

   // last stage is the output, depth edges after d
   assign q = stage[depth-1];

endmodule

/* rtl/dsp_pkg.sv */
// ----------------------------------------------------------
// port widths and post-adder modes of the multiply slice model
// only the features used by the 35x35 chain are described
// ----------------------------------------------------------
package dsp_pkg;

   // slice port widths
   localparam int A_W = 25;          // A operand, signed
   localparam int B_W = 18;          // B operand and B cascade
   localparam int M_W = A_W + B_W;   // registered multiplier product, 43 bits
   localparam int P_W = 48;          // result and product cascade

   // down-shift of the incoming product cascade
   localparam int CASC_SHIFT = 17;

   // slice A operand
   typedef logic [A_W-1:0] dsp_a_t;

   // slice B operand, also the B cascade tap
   typedef logic [B_W-1:0] dsp_b_t;

   // slice result, also the product cascade
   typedef logic [P_W-1:0] dsp_p_t;

   // source of the second post-adder input
   typedef enum logic [1:0] {
      add_none          = 2'd0,  // multiplier only
      add_cascade       = 2'd1,  // multiplier plus cascade
      add_cascade_shift = 2'd2   // multiplier plus cascade >> CASC_SHIFT
   } post_add_t;

endpackage

/* rtl/mult35_pipe.sv */
// ----------------------------------------------------------
// unsigned 35x35 -> 70 multiplier, one pair per cycle, 6 cycles
// no ready and no stall, in_valid only marks the result
// ----------------------------------------------------------
module mult35_pipe (
   input  logic               CLK,
   input  logic               RST,
   input  mult_pkg::operand_t a,
   input  mult_pkg::operand_t b,
   input  logic               in_valid,
   output mult_pkg::product_t prod,
   output logic               out_valid
);

   // operand limbs
   mult_pkg::limb_lo_t a_lo;
   mult_pkg::limb_hi_t a_hi;
   mult_pkg::limb_lo_t b_lo;
   mult_pkg::limb_hi_t b_hi;

   // limbs skewed for the later slices
   mult_pkg::limb_lo_t a_lo_d1;   // slice 3 A
   mult_pkg::limb_hi_t b_hi_d1;   // slice 3 B
   mult_pkg::limb_hi_t a_hi_d2;   // slice 4 A

   // slice results and cascades
   dsp_pkg::dsp_p_t p_1;          // only bits 16..0 are taken
   dsp_pkg::dsp_p_t p_3;          // only bits 16..0 are taken
   dsp_pkg::dsp_p_t p_4;          // only bits 35..0 are taken
   dsp_pkg::dsp_p_t p_casc_1;
   dsp_pkg::dsp_p_t p_casc_2;
   dsp_pkg::dsp_p_t p_casc_3;
   dsp_pkg::dsp_b_t b_casc_1;     // b_lo after one register
   dsp_pkg::dsp_b_t b_casc_3;     // b_hi after skew and one register

   // product fields aligned to edge 6
   mult_pkg::limb_lo_t field_lo;  // prod[16:0]
   mult_pkg::limb_lo_t field_mid; // prod[33:17]

   assign a_lo = a[mult_pkg::LIMB_LO_W-1:0];
   assign a_hi = a[mult_pkg::OPERAND_W-1:mult_pkg::LIMB_LO_W];
   assign b_lo = b[mult_pkg::LIMB_LO_W-1:0];
   assign b_hi = b[mult_pkg::OPERAND_W-1:mult_pkg::LIMB_LO_W];

   // slice 1, a_lo * b_lo, result after edge 3
   mult_slice #(
      .a_regs    (1),
      .b_regs    (1),
      .post_mode (dsp_pkg::add_none)
   ) slice_1 (
      .CLK       (CLK),
      .RST       (RST),
      .a         (dsp_pkg::dsp_a_t'(a_lo)),   // unsigned casts zero-extend
      .b         (dsp_pkg::dsp_b_t'(b_lo)),
      .p_casc_in ('0),
      .p         (p_1),
      .p_casc    (p_casc_1),
      .b_casc    (b_casc_1)
   );

   // slice 2, a_hi * b_lo + (p_1 >> 17), result after edge 4
   mult_slice #(
      .a_regs    (2),
      .b_regs    (1),                          // b already has one register in slice 1
      .post_mode (dsp_pkg::add_cascade_shift)
   ) slice_2 (
      .CLK       (CLK),
      .RST       (RST),
      .a         (dsp_pkg::dsp_a_t'(a_hi)),
      .b         (b_casc_1),
      .p_casc_in (p_casc_1),
      .p         (),                           // only the cascade is needed
      .p_casc    (p_casc_2),
      .b_casc    ()
   );

   // slice 3 inputs, one cycle late
   delay_line #(
      .depth (1),
      .width (mult_pkg::LIMB_LO_W)
   ) skew_a_3 (
      .CLK (CLK),
      .RST (RST),
      .d   (a_lo),
      .q   (a_lo_d1)
   );

   delay_line #(
      .depth (1),
      .width (mult_pkg::LIMB_HI_W)
   ) skew_b_3 (
      .CLK (CLK),
      .RST (RST),
      .d   (b_hi),
      .q   (b_hi_d1)
   );

   // slice 3, a_lo * b_hi + p_2, result after edge 5
   mult_slice #(
      .a_regs    (2),
      .b_regs    (2),
      .post_mode (dsp_pkg::add_cascade)
   ) slice_3 (
      .CLK       (CLK),
      .RST       (RST),
      .a         (dsp_pkg::dsp_a_t'(a_lo_d1)),
      .b         (dsp_pkg::dsp_b_t'(b_hi_d1)),  // 18 bits, no extension needed
      .p_casc_in (p_casc_2),
      .p         (p_3),
      .p_casc    (p_casc_3),
      .b_casc    (b_casc_3)
   );

   // slice 4 A, two cycles late
   delay_line #(
      .depth (2),
      .width (mult_pkg::LIMB_HI_W)
   ) skew_a_4 (
      .CLK (CLK),
      .RST (RST),
      .d   (a_hi),
      .q   (a_hi_d2)
   );

   // slice 4, a_hi * b_hi + (p_3 >> 17), result after edge 6
   mult_slice #(
      .a_regs    (2),
      .b_regs    (2),
      .post_mode (dsp_pkg::add_cascade_shift)
   ) slice_4 (
      .CLK       (CLK),
      .RST       (RST),
      .a         (dsp_pkg::dsp_a_t'(a_hi_d2)),
      .b         (b_casc_3),
      .p_casc_in (p_casc_3),
      .p         (p_4),
      .p_casc    (),                           // end of chain
      .b_casc    ()
   );

   // low field, edge 3 -> edge 6
   delay_line #(
      .depth (3),
      .width (mult_pkg::LIMB_LO_W)
   ) align_lo (
      .CLK (CLK),
      .RST (RST),
      .d   (p_1[mult_pkg::LIMB_LO_W-1:0]),
      .q   (field_lo)
   );

   // middle field, edge 5 -> edge 6
   delay_line #(
      .depth (1),
      .width (mult_pkg::LIMB_LO_W)
   ) align_mid (
      .CLK (CLK),
      .RST (RST),
      .d   (p_3[mult_pkg::LIMB_LO_W-1:0]),
      .q   (field_mid)
   );

   // valid follows the data through the whole pipe
   delay_line #(
      .depth (mult_pkg::PIPE_LATENCY),
      .width (1)
   ) valid_line (
      .CLK (CLK),
      .RST (RST),
      .d   (in_valid),
      .q   (out_valid)
   );

   // p_4 carries bits 69..34, its upper 12 bits are always zero
   assign prod = {p_4[mult_pkg::PRODUCT_W-2*mult_pkg::LIMB_LO_W-1:0], field_mid, field_lo};

endmodule

/* rtl/mult_pkg.sv */
// ----------------------------------------------------------
// widths and latency of the unsigned 35x35 multiplier
// operands are unsigned, the product keeps all 70 bits
// ----------------------------------------------------------
package mult_pkg;

   // operand split into a 17-bit low limb and an 18-bit high limb
   localparam int OPERAND_W = 35;
   localparam int LIMB_LO_W = 17;                     // also the field width of the cascade shift
   localparam int LIMB_HI_W = OPERAND_W - LIMB_LO_W;  // 18, fits the slice B port
   localparam int PRODUCT_W = 2 * OPERAND_W;          // full width, no truncation

   // edges from operand sample to product out
   localparam int PIPE_LATENCY = 6;

   // one multiplier operand
   typedef logic [OPERAND_W-1:0] operand_t;

   // low limb, bits 16..0 of an operand
   typedef logic [LIMB_LO_W-1:0] limb_lo_t;

   // high limb, bits 34..17 of an operand
   typedef logic [LIMB_HI_W-1:0] limb_hi_t;

   // full product
   typedef logic [PRODUCT_W-1:0] product_t;

endpackage

/* rtl/mult_slice.sv */
// ----------------------------------------------------------
// behavioral multiply-add slice, A/B depth 1 or 2, M and P regs
// A is signed 25 bit, B is taken as an unsigned 18-bit limb
// ----------------------------------------------------------
module mult_slice #(
   parameter int                 a_regs    = 1,                 // A register depth, 1 or 2
   parameter int                 b_regs    = 1,                 // B register depth, 1 or 2
   parameter dsp_pkg::post_add_t post_mode = dsp_pkg::add_none  // second adder input
) (
   input  logic            CLK,
   input  logic            RST,
   input  dsp_pkg::dsp_a_t a,          // zero-extended limb
   input  dsp_pkg::dsp_b_t b,          // limb or B cascade of the previous slice
   input  dsp_pkg::dsp_p_t p_casc_in,  // product cascade of the previous slice
   output dsp_pkg::dsp_p_t p,
   output dsp_pkg::dsp_p_t p_casc,
   output dsp_pkg::dsp_b_t b_casc
);

   // input registers, first and second stage
   dsp_pkg::dsp_a_t a_r1;
   dsp_pkg::dsp_a_t a_r2;
   dsp_pkg::dsp_b_t b_r1;
   dsp_pkg::dsp_b_t b_r2;

   // operands seen by the multiplier
   dsp_pkg::dsp_a_t a_q;
   dsp_pkg::dsp_b_t b_q;

   // multiplier product and its register
   logic signed [dsp_pkg::M_W-1:0] m_prod;
   logic signed [dsp_pkg::M_W-1:0] m_r;

   // post-adder terms
   dsp_pkg::dsp_p_t m_ext;      // m_r sign-extended to P width
   dsp_pkg::dsp_p_t casc_term;  // cascade term picked by post_mode
   dsp_pkg::dsp_p_t p_sum;      // adder output before the P register
   dsp_pkg::dsp_p_t p_r;        // P register

   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         a_r1 <= '0;
         a_r2 <= '0;
         b_r1 <= '0;
         b_r2 <= '0;
      end
      else
      begin
         a_r1 <= a;
         a_r2 <= a_r1;   // only looked at when a_regs is 2
         b_r1 <= b;
         b_r2 <= b_r1;   // only looked at when b_regs is 2
      end
   end

   // pick the configured depth
   assign a_q = (a_regs == 2) ? a_r2 : a_r1;
   assign b_q = (b_regs == 2) ? b_r2 : b_r1;

   // B gets a zero sign bit so an 18-bit high limb stays positive,
   // A is zero-extended by the caller so its sign bit is never set
   assign m_prod = $signed(a_q) * $signed({1'b0, b_q});

   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         m_r <= '0;
      end
      else
      begin
         m_r <= m_prod;   // multiplier pipeline stage
      end
   end

   // sign-extend 43 -> 48
   assign m_ext = {{(dsp_pkg::P_W - dsp_pkg::M_W){m_r[dsp_pkg::M_W-1]}}, m_r};

   always_comb
   begin
      case (post_mode)
         dsp_pkg::add_none:
         begin
            casc_term = '0;            // first slice of a chain
         end
         dsp_pkg::add_cascade:
         begin
            casc_term = p_casc_in;     // same weight as this product
         end
         dsp_pkg::add_cascade_shift:
         begin
            // previous sum moved down one limb, arithmetic shift as in the primitive
            casc_term = dsp_pkg::dsp_p_t'($signed(p_casc_in) >>> dsp_pkg::CASC_SHIFT);
         end
         default:
         begin
            casc_term = '0;
         end
      endcase
   end

   assign p_sum = m_ext + casc_term;   // wraps at 48 bits like the hardware

   always_ff @(posedge CLK or posedge RST)
   begin
      if (RST)
      begin
         p_r <= '0;
      end
      else
      begin
         p_r <= p_sum;
      end
   end

   assign p      = p_r;
   assign p_casc = p_r;    // dedicated cascade copy of P
   assign b_casc = b_r1;   // tap after the first B register

endmodule
